// File: hdl/mci_consts.svh
////////////////////
// MCI control core constants
// Register port widths, register count and reset values
////////////////////
`ifndef MCI_CONSTS_SVH
`define MCI_CONSTS_SVH

// Register port
`define MCI_DATA_W 32
`define MCI_ADDR_W 4
`define MCI_REG_NUM 10

// Fatal error aggregation
`define MCI_ERR_W 32
`define MCI_ERR_MASK_RST 32'h0000_0000

// Boot state code width
`define MCI_BOOT_ST_W 3

// Watchdog periods out of reset
`define MCI_WDT_PERIOD_RST 32'hFFFF_FFFF

`endif

// File: hdl/mci_reg_pkg.sv
////////////////////
// MCI register map types
// Address map of the control register bank and watchdog status layout
////////////////////
`include "mci_consts.svh"

package mci_reg_pkg;

    // Register addresses, anything above BOOT_STATUS is unmapped
    typedef enum logic [`MCI_ADDR_W-1:0] {
        BOOTFSM_GO        = 4'd0,
        CPTRA_BOOT_GO     = 4'd1,
        WDT_TIMER1_EN     = 4'd2,
        WDT_TIMER1_CTRL   = 4'd3,
        WDT_TIMER1_PERIOD = 4'd4,
        WDT_TIMER2_PERIOD = 4'd5,
        WDT_STATUS        = 4'd6,
        ERROR_FATAL_MASK  = 4'd7,
        HW_ERROR_FATAL    = 4'd8,
        BOOT_STATUS       = 4'd9
    } mci_reg_addr_e;

    // Watchdog status as read at WDT_STATUS
    typedef struct packed {
        logic t2_timeout;
        logic t1_timeout;
    } mci_wdt_status_t;

endpackage

// File: hdl/mci_boot_pkg.sv
////////////////////
// MCI boot sequencer types
// State codes, also reported through BOOT_STATUS
////////////////////
`include "mci_consts.svh"

package mci_boot_pkg;

    // Boot flow in order, breakpoint is optional
    typedef enum logic [`MCI_BOOT_ST_W-1:0] {
        BOOT_IDLE          = 3'd0,
        BOOT_BREAKPOINT    = 3'd1,
        BOOT_OTP_FC        = 3'd2,
        BOOT_LCC           = 3'd3,
        BOOT_MCU_RST       = 3'd4,
        BOOT_WAIT_CPTRA_GO = 3'd5,
        BOOT_DONE          = 3'd6
    } mci_boot_state_e;

endpackage

// File: hdl/mci_boot_seqr.sv
////////////////////
// MCI boot sequencer
// Steps through fuse init, lifecycle init, MCU reset release
// and Caliptra reset release, with an optional breakpoint hold
////////////////////
`timescale 1ns/1ps

module mci_boot_seqr (
    input  logic                          clk,
    input  logic                          reset_i,

    // Boot controls
    input  logic                          boot_brkpoint_i,
    input  logic                          bootfsm_go_i,
    input  logic                          cptra_boot_go_i,

    // Fuse and lifecycle handshakes
    input  logic                          fc_opt_done_i,
    input  logic                          lc_done_i,
    output logic                          fc_opt_init_o,
    output logic                          lc_init_o,

    // Reset releases
    output logic                          mcu_rst_b_o,
    output logic                          cptra_rst_b_o,

    output mci_boot_pkg::mci_boot_state_e boot_state_o
);

    import mci_boot_pkg::*;

    mci_boot_state_e state_q;
    mci_boot_state_e state_d;

    ////////////////////
    // Next state
    ////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            BOOT_IDLE: begin
                // Breakpoint strap is sampled once, right after reset
                state_d = boot_brkpoint_i ? BOOT_BREAKPOINT : BOOT_OTP_FC;
            end
            BOOT_BREAKPOINT: begin
                if (bootfsm_go_i) begin
                    state_d = BOOT_OTP_FC;
                end
            end
            BOOT_OTP_FC: begin
                if (fc_opt_done_i) begin
                    state_d = BOOT_LCC;
                end
            end
            BOOT_LCC: begin
                if (lc_done_i) begin
                    state_d = BOOT_MCU_RST;
                end
            end
            BOOT_MCU_RST: begin
                state_d = BOOT_WAIT_CPTRA_GO;
            end
            BOOT_WAIT_CPTRA_GO: begin
                if (cptra_boot_go_i) begin
                    state_d = BOOT_DONE;
                end
            end
            BOOT_DONE: begin
                state_d = BOOT_DONE;
            end
            default: begin
                state_d = BOOT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= BOOT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////
    // Outputs from state
    ////////////////////
    assign fc_opt_init_o = (state_q == BOOT_OTP_FC);
    assign lc_init_o     = (state_q == BOOT_LCC);

    // MCU stays out of reset from BOOT_MCU_RST on
    assign mcu_rst_b_o   = (state_q == BOOT_MCU_RST) ||
                           (state_q == BOOT_WAIT_CPTRA_GO) ||
                           (state_q == BOOT_DONE);
    // Only reachable after the MCU release
    assign cptra_rst_b_o = (state_q == BOOT_DONE);

    assign boot_state_o  = state_q;

endmodule

// File: hdl/mci_wdt.sv
////////////////////
// MCI watchdog
// Two cascaded timers, second expiry latches the NMI
////////////////////
`timescale 1ns/1ps
`include "mci_consts.svh"

module mci_wdt (
    input  logic                         clk,
    input  logic                         reset_i,

    // Controls from the register bank
    input  logic                         timer1_en_i,
    input  logic                         timer1_restart_i,
    input  logic [`MCI_DATA_W-1:0]       timer1_period_i,
    input  logic [`MCI_DATA_W-1:0]       timer2_period_i,

    output mci_reg_pkg::mci_wdt_status_t wdt_status_o,
    output logic                         nmi_intr_o
);

    logic [`MCI_DATA_W-1:0] cnt1_q;
    logic [`MCI_DATA_W-1:0] cnt2_q;
    logic                   t1_timeout_q;
    logic                   t2_timeout_q;
    logic                   t1_expire;
    logic                   t2_expire;

    // Expiry is taken one cycle after the count reaches the period
    assign t1_expire = timer1_en_i && !t1_timeout_q && (cnt1_q >= timer1_period_i);
    assign t2_expire = t1_timeout_q && !t2_timeout_q && (cnt2_q >= timer2_period_i);

    ////////////////////
    // Counters and status
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset_i || timer1_restart_i) begin
            cnt1_q       <= '0;
            cnt2_q       <= '0;
            t1_timeout_q <= 1'b0;
            t2_timeout_q <= 1'b0;
        end else begin
            // Stage 1 runs while enabled and not yet expired
            if (t1_expire) begin
                t1_timeout_q <= 1'b1;
            end else if (timer1_en_i && !t1_timeout_q) begin
                cnt1_q <= cnt1_q + 1'b1;
            end

            // Stage 2 only counts after stage 1 expired
            if (t2_expire) begin
                t2_timeout_q <= 1'b1;
            end else if (t1_timeout_q && !t2_timeout_q) begin
                cnt2_q <= cnt2_q + 1'b1;
            end
        end
    end

    // NMI is sticky, a restart does not clear it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            nmi_intr_o <= 1'b0;
        end else if (t2_expire && !timer1_restart_i) begin
            nmi_intr_o <= 1'b1;
        end
    end

    assign wdt_status_o.t1_timeout = t1_timeout_q;
    assign wdt_status_o.t2_timeout = t2_timeout_q;

endmodule

// File: hdl/mci_reg_bank.sv
////////////////////
// MCI register bank
// Four-phase req/ack port, boot and watchdog controls,
// sticky fatal errors with mask and aggregated fatal output
////////////////////
`timescale 1ns/1ps
`include "mci_consts.svh"

module mci_reg_bank (
    input  logic                          clk,
    input  logic                          reset_i,

    // Register port
    input  logic                          reg_req_i,
    input  logic                          reg_we_i,
    input  logic [`MCI_ADDR_W-1:0]        reg_addr_i,
    input  logic [`MCI_DATA_W-1:0]        reg_wdata_i,
    output logic                          reg_ack_o,
    output logic [`MCI_DATA_W-1:0]        reg_rdata_o,

    // Status inputs
    input  logic [`MCI_ERR_W-1:0]         agg_error_fatal_i,
    input  mci_boot_pkg::mci_boot_state_e boot_state_i,
    input  mci_reg_pkg::mci_wdt_status_t  wdt_status_i,

    // Control outputs
    output logic                          bootfsm_go_o,
    output logic                          cptra_boot_go_o,
    output logic                          timer1_en_o,
    output logic                          timer1_restart_o,
    output logic [`MCI_DATA_W-1:0]        timer1_period_o,
    output logic [`MCI_DATA_W-1:0]        timer2_period_o,
    output logic                          all_error_fatal_o
);

    import mci_reg_pkg::*;

    mci_reg_addr_e          addr;
    logic                   take;
    logic                   addr_hit;
    logic                   wr_en;
    logic [`MCI_DATA_W-1:0] rd_mux;
    logic [`MCI_ERR_W-1:0]  err_mask_q;
    logic [`MCI_ERR_W-1:0]  hw_err_q;
    logic [`MCI_ERR_W-1:0]  err_clr;

    ////////////////////
    // Handshake
    ////////////////////
    // New access only once the previous ack has dropped
    assign take     = reg_req_i && !reg_ack_o;
    assign addr     = mci_reg_addr_e'(reg_addr_i);
    assign addr_hit = (reg_addr_i < `MCI_REG_NUM);
    assign wr_en    = take && reg_we_i && addr_hit;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_ack_o <= 1'b0;
        end else if (take) begin
            reg_ack_o <= 1'b1;
        end else if (!reg_req_i) begin
            reg_ack_o <= 1'b0;
        end
    end

    // Read data held for as long as ack is up
    always_ff @(posedge clk) begin
        if (take && !reg_we_i) begin
            reg_rdata_o <= rd_mux;
        end
    end

    ////////////////////
    // Control registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bootfsm_go_o    <= 1'b0;
            cptra_boot_go_o <= 1'b0;
            timer1_en_o     <= 1'b0;
            timer1_period_o <= `MCI_WDT_PERIOD_RST;
            timer2_period_o <= `MCI_WDT_PERIOD_RST;
            err_mask_q      <= `MCI_ERR_MASK_RST;
        end else if (wr_en) begin
            case (addr)
                BOOTFSM_GO:        bootfsm_go_o    <= reg_wdata_i[0];
                CPTRA_BOOT_GO:     cptra_boot_go_o <= reg_wdata_i[0];
                WDT_TIMER1_EN:     timer1_en_o     <= reg_wdata_i[0];
                WDT_TIMER1_PERIOD: timer1_period_o <= reg_wdata_i;
                WDT_TIMER2_PERIOD: timer2_period_o <= reg_wdata_i;
                ERROR_FATAL_MASK:  err_mask_q      <= reg_wdata_i;
                default: begin
                end
            endcase
        end
    end

    // Restart is a single pulse per write with bit 0 set
    always_ff @(posedge clk) begin
        if (reset_i) begin
            timer1_restart_o <= 1'b0;
        end else begin
            timer1_restart_o <= wr_en && (addr == WDT_TIMER1_CTRL) && reg_wdata_i[0];
        end
    end

    ////////////////////
    // Fatal errors
    ////////////////////
    assign err_clr = (wr_en && (addr == HW_ERROR_FATAL)) ? reg_wdata_i : '0;

    // A new error in the clearing cycle wins
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hw_err_q          <= '0;
            all_error_fatal_o <= 1'b0;
        end else begin
            hw_err_q          <= (hw_err_q & ~err_clr) | agg_error_fatal_i;
            all_error_fatal_o <= |(hw_err_q & ~err_mask_q);
        end
    end

    ////////////////////
    // Read mux
    ////////////////////
    always_comb begin
        rd_mux = '0;
        case (addr)
            BOOTFSM_GO:        rd_mux[0] = bootfsm_go_o;
            CPTRA_BOOT_GO:     rd_mux[0] = cptra_boot_go_o;
            WDT_TIMER1_EN:     rd_mux[0] = timer1_en_o;
            WDT_TIMER1_PERIOD: rd_mux    = timer1_period_o;
            WDT_TIMER2_PERIOD: rd_mux    = timer2_period_o;
            WDT_STATUS:        rd_mux[1:0] = wdt_status_i;
            ERROR_FATAL_MASK:  rd_mux    = err_mask_q;
            HW_ERROR_FATAL:    rd_mux    = hw_err_q;
            BOOT_STATUS:       rd_mux[`MCI_BOOT_ST_W-1:0] = boot_state_i;
            // Restart control and unmapped addresses read zero
            default:           rd_mux    = '0;
        endcase
    end

endmodule

// File: hdl/mci_top.sv
////////////////////
// MCI control core top
// Boot sequencer, watchdog and register bank
////////////////////
`timescale 1ns/1ps
`include "mci_consts.svh"

module mci_top (
    input  logic                   clk,
    input  logic                   reset_i,

    // Register port
    input  logic                   reg_req_i,
    input  logic                   reg_we_i,
    input  logic [`MCI_ADDR_W-1:0] reg_addr_i,
    input  logic [`MCI_DATA_W-1:0] reg_wdata_i,
    output logic                   reg_ack_o,
    output logic [`MCI_DATA_W-1:0] reg_rdata_o,

    // Fatal errors
    input  logic [`MCI_ERR_W-1:0]  agg_error_fatal_i,
    output logic                   all_error_fatal_o,

    // Boot flow
    input  logic                   boot_brkpoint_i,
    input  logic                   fc_opt_done_i,
    input  logic                   lc_done_i,
    output logic                   fc_opt_init_o,
    output logic                   lc_init_o,
    output logic                   mcu_rst_b_o,
    output logic                   cptra_rst_b_o,

    output logic                   nmi_intr_o
);

    import mci_reg_pkg::*;
    import mci_boot_pkg::*;

    logic                   bootfsm_go;
    logic                   cptra_boot_go;
    logic                   timer1_en;
    logic                   timer1_restart;
    logic [`MCI_DATA_W-1:0] timer1_period;
    logic [`MCI_DATA_W-1:0] timer2_period;
    mci_boot_state_e        boot_state;
    mci_wdt_status_t        wdt_status;

    mci_boot_seqr u_boot_seqr (
        .clk             (clk),
        .reset_i         (reset_i),
        .boot_brkpoint_i (boot_brkpoint_i),
        .bootfsm_go_i    (bootfsm_go),
        .cptra_boot_go_i (cptra_boot_go),
        .fc_opt_done_i   (fc_opt_done_i),
        .lc_done_i       (lc_done_i),
        .fc_opt_init_o   (fc_opt_init_o),
        .lc_init_o       (lc_init_o),
        .mcu_rst_b_o     (mcu_rst_b_o),
        .cptra_rst_b_o   (cptra_rst_b_o),
        .boot_state_o    (boot_state)
    );

    mci_wdt u_wdt (
        .clk              (clk),
        .reset_i          (reset_i),
        .timer1_en_i      (timer1_en),
        .timer1_restart_i (timer1_restart),
        .timer1_period_i  (timer1_period),
        .timer2_period_i  (timer2_period),
        .wdt_status_o     (wdt_status),
        .nmi_intr_o       (nmi_intr_o)
    );

    mci_reg_bank u_reg_bank (
        .clk               (clk),
        .reset_i           (reset_i),
        .reg_req_i         (reg_req_i),
        .reg_we_i          (reg_we_i),
        .reg_addr_i        (reg_addr_i),
        .reg_wdata_i       (reg_wdata_i),
        .reg_ack_o         (reg_ack_o),
        .reg_rdata_o       (reg_rdata_o),
        .agg_error_fatal_i (agg_error_fatal_i),
        .boot_state_i      (boot_state),
        .wdt_status_i      (wdt_status),
        .bootfsm_go_o      (bootfsm_go),
        .cptra_boot_go_o   (cptra_boot_go),
        .timer1_en_o       (timer1_en),
        .timer1_restart_o  (timer1_restart),
        .timer1_period_o   (timer1_period),
        .timer2_period_o   (timer2_period),
        .all_error_fatal_o (all_error_fatal_o)
    );

endmodule

// File: dv/mci_top_checker.sv
////////////////////
// MCI control core checker
// Concurrent properties on the register handshake, reset ordering and NMI
////////////////////
`timescale 1ns/1ps

module mci_top_checker (
    input logic clk,
    input logic reset_i,
    input logic req_i,
    input logic ack_i,
    input logic mcu_rst_b_i,
    input logic cptra_rst_b_i,
    input logic nmi_i
);

    // Failures seen so far, read by the testbench at the end of the run
    int fail_cnt = 0;

    ////////////////////
    // Register handshake
    ////////////////////
    ack_rise_a: assert property (@(posedge clk) disable iff (reset_i)
        $rose(ack_i) |-> $past(req_i))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("ack rose without a request pending");
    end

    ack_hold_a: assert property (@(posedge clk) disable iff (reset_i)
        (ack_i && req_i) |=> ack_i)
    else begin
        fail_cnt = fail_cnt + 1;
        $error("ack dropped while the request was still high");
    end

    ////////////////////
    // Boot and watchdog
    ////////////////////
    rst_order_a: assert property (@(posedge clk) disable iff (reset_i)
        !(cptra_rst_b_i && !mcu_rst_b_i))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("Caliptra released from reset while the MCU is held");
    end

    // Sticky until reset
    nmi_sticky_a: assert property (@(posedge clk) disable iff (reset_i)
        !$fell(nmi_i))
    else begin
        fail_cnt = fail_cnt + 1;
        $error("NMI fell outside of reset");
    end

endmodule

bind mci_top mci_top_checker u_checker (
    .clk           (clk),
    .reset_i       (reset_i),
    .req_i         (reg_req_i),
    .ack_i         (reg_ack_o),
    .mcu_rst_b_i   (mcu_rst_b_o),
    .cptra_rst_b_i (cptra_rst_b_o),
    .nmi_i         (nmi_intr_o)
);

// File: dv/mci_top_tb.sv
////////////////////
// MCI control core testbench
// Boot flow, register table, fatal errors, watchdog and handshake checks
////////////////////
`timescale 1ns/1ps
`include "mci_consts.svh"

module mci_top_tb;

    import mci_reg_pkg::*;

    localparam int max_wait_cycles = 50;
    localparam int sig_fc          = 0;
    localparam int sig_lc          = 1;
    localparam int sig_mcu         = 2;
    localparam int sig_cptra       = 3;

    typedef struct {
        logic                   we;
        logic [`MCI_ADDR_W-1:0] addr;
        logic [`MCI_DATA_W-1:0] data;
        logic [`MCI_DATA_W-1:0] exp;
    } reg_row_t;

    logic                   clk;
    logic                   reset_i;
    logic                   reg_req_i;
    logic                   reg_we_i;
    logic [`MCI_ADDR_W-1:0] reg_addr_i;
    logic [`MCI_DATA_W-1:0] reg_wdata_i;
    logic                   reg_ack_o;
    logic [`MCI_DATA_W-1:0] reg_rdata_o;
    logic [`MCI_ERR_W-1:0]  agg_error_fatal_i;
    logic                   all_error_fatal_o;
    logic                   boot_brkpoint_i;
    logic                   fc_opt_done_i;
    logic                   lc_done_i;
    logic                   fc_opt_init_o;
    logic                   lc_init_o;
    logic                   mcu_rst_b_o;
    logic                   cptra_rst_b_o;
    logic                   nmi_intr_o;

    int       err_cnt;
    reg_row_t rows[$];

    mci_top u_mci_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic next_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            sig_fc:  probe = fc_opt_init_o;
            sig_lc:  probe = lc_init_o;
            sig_mcu: probe = mcu_rst_b_o;
            default: probe = cptra_rst_b_o;
        endcase
    endfunction

    task automatic wait_level(input int sel, input logic level, input string name);
        int cyc;
        cyc = 0;
        while (probe(sel) !== level && cyc < max_wait_cycles) begin
            next_cycles(1);
            cyc++;
        end
        assert (probe(sel) === level) else begin
            $display("Timed out after %0d cycles waiting for %s to go %0b",
                     max_wait_cycles, name, level);
            err_cnt++;
        end
    endtask

    ////////////////////
    // Register port
    ////////////////////
    // Four-phase access
    // Hold keeps req high for that many extra cycles
    task automatic reg_access(input logic we, input logic [`MCI_ADDR_W-1:0] addr,
                              input logic [`MCI_DATA_W-1:0] wdata, input int hold,
                              output logic [`MCI_DATA_W-1:0] rdata);
        int cyc;
        int i;
        reg_we_i    = we;
        reg_addr_i  = addr;
        reg_wdata_i = wdata;
        reg_req_i   = 1'b1;
        cyc = 0;
        while (!reg_ack_o && cyc < max_wait_cycles) begin
            next_cycles(1);
            cyc++;
        end
        assert (reg_ack_o) else begin
            $display("Access to address %0d got no ack within %0d cycles", addr, cyc);
            err_cnt++;
        end
        rdata = reg_rdata_o;
        for (i = 0; i < hold; i++) begin
            next_cycles(1);
            check_equal("ack while req held", reg_ack_o, 1);
            check_equal("read data while req held", reg_rdata_o, rdata);
        end
        reg_req_i = 1'b0;
        cyc = 0;
        while (reg_ack_o && cyc < max_wait_cycles) begin
            next_cycles(1);
            cyc++;
        end
        assert (!reg_ack_o) else begin
            $display("Ack for address %0d stayed high after req dropped", addr);
            err_cnt++;
        end
    endtask

    task automatic poll_bit(input logic [`MCI_ADDR_W-1:0] addr, input int idx,
                            input string name, output logic [`MCI_DATA_W-1:0] rd);
        int n;
        n = 0;
        reg_access(1'b0, addr, '0, 0, rd);
        while (!rd[idx] && n < max_wait_cycles) begin
            reg_access(1'b0, addr, '0, 0, rd);
            n++;
        end
        assert (rd[idx]) else begin
            $display("Timed out after %0d reads polling for %s", n, name);
            err_cnt++;
        end
    endtask

    // Write then read back
    function automatic void add_rw(input logic [`MCI_ADDR_W-1:0] addr,
                                   input logic [31:0] data, input logic [31:0] exp);
        reg_row_t row;
        row.we   = 1'b1;
        row.addr = addr;
        row.data = data;
        row.exp  = '0;
        rows.push_back(row);
        row.we   = 1'b0;
        row.data = '0;
        row.exp  = exp;
        rows.push_back(row);
    endfunction

    initial begin
        logic [31:0] rd;
        logic [31:0] v;
        logic [31:0] bits;
        logic [31:0] masks[3];
        int          a;

        void'($urandom(32'he052d368));
        err_cnt           = 0;
        reset_i           = 1'b1;
        reg_req_i         = 1'b0;
        reg_we_i          = 1'b0;
        reg_addr_i        = '0;
        reg_wdata_i       = '0;
        agg_error_fatal_i = '0;
        boot_brkpoint_i   = 1'b1;
        fc_opt_done_i     = 1'b0;
        lc_done_i         = 1'b0;
        next_cycles(16);
        reset_i = 1'b0;

        check_equal("control outputs after reset",
                    {reg_ack_o, lc_init_o, fc_opt_init_o, mcu_rst_b_o,
                     cptra_rst_b_o, nmi_intr_o, all_error_fatal_o}, 0);

        ////////////////////
        // Boot with breakpoint
        ////////////////////
        next_cycles(4);
        check_equal("init requests at breakpoint", {fc_opt_init_o, lc_init_o}, 0);
        reg_access(1'b0, BOOT_STATUS, '0, 0, rd);
        check_equal("boot state at breakpoint", rd, 32'd1);
        check_equal("init requests at breakpoint", {fc_opt_init_o, lc_init_o}, 0);
        reg_access(1'b1, BOOTFSM_GO, 32'h1, 0, rd);

        wait_level(sig_fc, 1'b1, "fc_opt_init_o");
        next_cycles($urandom_range(1, 6));
        fc_opt_done_i = 1'b1;
        wait_level(sig_fc, 1'b0, "fc_opt_init_o");
        fc_opt_done_i = 1'b0;
        wait_level(sig_lc, 1'b1, "lc_init_o");
        next_cycles($urandom_range(1, 6));
        lc_done_i = 1'b1;
        wait_level(sig_lc, 1'b0, "lc_init_o");
        lc_done_i = 1'b0;
        wait_level(sig_mcu, 1'b1, "mcu_rst_b_o");

        next_cycles(3);
        check_equal("cptra_rst_b_o before boot go", cptra_rst_b_o, 0);
        reg_access(1'b0, BOOT_STATUS, '0, 0, rd);
        check_equal("boot state waiting for go", rd, 32'd5);
        reg_access(1'b1, CPTRA_BOOT_GO, 32'h1, 0, rd);
        wait_level(sig_cptra, 1'b1, "cptra_rst_b_o");
        reg_access(1'b0, BOOT_STATUS, '0, 0, rd);
        check_equal("boot state when done", rd, 32'd6);

        ////////////////////
        // Register table
        ////////////////////
        v = $urandom();
        add_rw(BOOTFSM_GO, v, v & 32'h1);
        v = $urandom();
        add_rw(CPTRA_BOOT_GO, v, v & 32'h1);
        v = $urandom();
        add_rw(WDT_TIMER1_EN, v, v & 32'h1);
        // Bit 31 set keeps the watchdog far from expiry
        v = $urandom() | 32'h8000_0000;
        add_rw(WDT_TIMER1_PERIOD, v, v);
        v = $urandom() | 32'h8000_0000;
        add_rw(WDT_TIMER2_PERIOD, v, v);
        v = $urandom();
        add_rw(ERROR_FATAL_MASK, v, v);
        add_rw(WDT_TIMER1_CTRL, $urandom(), 32'h0);
        add_rw(WDT_STATUS, $urandom(), 32'h0);
        add_rw(BOOT_STATUS, $urandom(), 32'd6);
        for (a = 10; a < 16; a++) begin
            add_rw(a[`MCI_ADDR_W-1:0], $urandom(), 32'h0);
        end

        foreach (rows[r]) begin
            reg_access(rows[r].we, rows[r].addr, rows[r].data, 0, rd);
            if (!rows[r].we) begin
                check_equal($sformatf("read of address %0d", rows[r].addr), rd, rows[r].exp);
            end
        end

        ////////////////////
        // Fatal errors
        ////////////////////
        bits = $urandom() | (32'h1 << $urandom_range(0, 31));
        agg_error_fatal_i = bits;
        next_cycles(1);
        agg_error_fatal_i = '0;
        masks[0] = bits;
        masks[1] = $urandom();
        masks[2] = '0;
        // High unless the mask covers every latched bit
        foreach (masks[m]) begin
            reg_access(1'b1, ERROR_FATAL_MASK, masks[m], 0, rd);
            next_cycles(2);
            check_equal("all_error_fatal_o with mask", all_error_fatal_o,
                        (bits & masks[m]) != bits);
        end
        reg_access(1'b0, HW_ERROR_FATAL, '0, 0, rd);
        check_equal("latched fatal errors", rd, bits);
        reg_access(1'b1, HW_ERROR_FATAL, bits, 0, rd);
        next_cycles(2);
        reg_access(1'b0, HW_ERROR_FATAL, '0, 0, rd);
        check_equal("fatal errors after clear", rd, 32'h0);
        check_equal("all_error_fatal_o after clear", all_error_fatal_o, 0);

        ////////////////////
        // Watchdog
        ////////////////////
        reg_access(1'b1, WDT_TIMER1_EN, 32'h0, 0, rd);
        reg_access(1'b1, WDT_TIMER1_CTRL, 32'h1, 0, rd);
        reg_access(1'b1, WDT_TIMER1_PERIOD, 32'd10, 0, rd);
        reg_access(1'b1, WDT_TIMER2_PERIOD, 32'd300, 0, rd);
        reg_access(1'b1, WDT_TIMER1_EN, 32'h1, 0, rd);
        poll_bit(WDT_STATUS, 0, "stage 1 timeout", rd);
        check_equal("stage 2 timeout before restart", rd[1], 0);
        reg_access(1'b1, WDT_TIMER1_CTRL, 32'h1, 0, rd);
        reg_access(1'b0, WDT_STATUS, '0, 0, rd);
        check_equal("watchdog status after restart", rd, 32'h0);
        check_equal("nmi_intr_o after stage 1", nmi_intr_o, 0);

        // Cascade into stage 2
        reg_access(1'b1, WDT_TIMER2_PERIOD, 32'd20, 0, rd);
        poll_bit(WDT_STATUS, 1, "stage 2 timeout", rd);
        check_equal("watchdog status at stage 2", rd, 32'h3);
        check_equal("nmi_intr_o at stage 2", nmi_intr_o, 1);
        reg_access(1'b1, WDT_TIMER1_EN, 32'h0, 0, rd);
        reg_access(1'b1, WDT_TIMER1_CTRL, 32'h1, 0, rd);
        reg_access(1'b0, WDT_STATUS, '0, 0, rd);
        check_equal("watchdog status after late restart", rd, 32'h0);
        check_equal("nmi_intr_o after restart", nmi_intr_o, 1);

        ////////////////////
        // Slow host
        ////////////////////
        v = $urandom();
        reg_access(1'b1, ERROR_FATAL_MASK, v, 0, rd);
        reg_access(1'b0, ERROR_FATAL_MASK, '0, 6, rd);
        check_equal("read with req held", rd, v);

        $display("Check errors: %0d, assertion failures: %0d",
                 err_cnt, u_mci_top.u_checker.fail_cnt);
        if (err_cnt == 0 && u_mci_top.u_checker.fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: mci_top.f
+incdir+hdl
hdl/mci_reg_pkg.sv
hdl/mci_boot_pkg.sv
hdl/mci_boot_seqr.sv
hdl/mci_wdt.sv
hdl/mci_reg_bank.sv
hdl/mci_top.sv
dv/mci_top_checker.sv
dv/mci_top_tb.sv

// File: Makefile
SRCS := $(shell grep -v '^+' mci_top.f) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vmci_top_tb: mci_top.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module mci_top_tb \
		-f mci_top.f -Mdir obj_dir -o Vmci_top_tb

run: obj_dir/Vmci_top_tb
	@out="$$(./obj_dir/Vmci_top_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
